// ==== lspMacros.svh ====
`ifndef LSP_MACROS_SVH
`define LSP_MACROS_SVH

////////////////////////////////////////
// LSP expand sizing
////////////////////////////////////////

// Coefficients in one LSP buffer
`define LSP_M 10

// Scratch memory address width, 2048 words
`define LSP_ADDR_W 11

// Scratch memory word width
`define LSP_DATA_W 32

// Width of the spacing gap input
`define LSP_GAP_W 4

`endif

// ==== lspPkg.sv ====
`include "lspMacros.svh"

package lspPkg;

	// Q-format coefficient, signed 16 bit
	typedef logic signed [15:0] word16;
	// Raw scratch word, coefficient sign-extended
	typedef logic [`LSP_DATA_W-1:0] word32;
	typedef logic [`LSP_ADDR_W-1:0] memAddr;
	// Minimum spacing, unsigned
	typedef logic [`LSP_GAP_W-1:0] gapVal;

	// Shared ALU operations
	typedef enum logic [1:0]
	{
		ADD,
		SUB,
		SHR1
	} aluOp;

	// Expand controller states, one index per sweep
	typedef enum logic [3:0]
	{
		IDLE,
		READ_A,
		READ_B,
		DIFF,
		ADDGAP,
		HALVE,
		UPDATE_A,
		UPDATE_B,
		WRITE_A,
		WRITE_B,
		NEXT,
		FINISH
	} expandState;

endpackage

// ==== satAlu16.sv ====
`timescale 1ns/100ps

module satAlu16
(
	input  lspPkg::word16 a,
	input  lspPkg::word16 b,
	input  lspPkg::aluOp op,
	output lspPkg::word16 result
);
	import lspPkg::*;

	// Saturation limits of a 16-bit word
	localparam word16 MaxPos = 16'sh7FFF;
	localparam word16 MaxNeg = 16'sh8000;

	// One extra bit to catch overflow
	logic [16:0] sumWide;
	logic [16:0] diffWide;
	logic [16:0] selWide;
	word16 satVal;
	word16 shrVal;

	////////////////////////////////////////
	// Add and subtract
	////////////////////////////////////////

	// Sign-extend both operands to 17 bits
	assign sumWide = {a[15], a} + {b[15], b};
	assign diffWide = {a[15], a} - {b[15], b};

	assign selWide = (op == SUB) ? diffWide : sumWide;

	// Top two bits disagree on overflow
	always_comb
	begin
		if (selWide[16] != selWide[15])
		begin
			// Bit 16 holds the true sign
			if (selWide[16])
				satVal = MaxNeg;
			else
				satVal = MaxPos;
		end
		else
			satVal = selWide[15:0];
	end

	////////////////////////////////////////
	// Shift and result select
	////////////////////////////////////////

	// Halving keeps the sign
	assign shrVal = a >>> 1;

	always_comb
	begin
		case (op)
			SHR1: result = shrVal;
			default: result = satVal;
		endcase
	end

	// Controller must always steer a legal operation
	opKnown: assert final (!$isunknown(op))
		else $error("satAlu16 op is unknown");

endmodule

// ==== scratchMemory.sv ====
`timescale 1ns/100ps
`include "lspMacros.svh"

module scratchMemory
(
	input  logic clk,
	input  lspPkg::memAddr writeAddr,
	input  lspPkg::memAddr readAddr,
	input  lspPkg::word32 writeData,
	input  logic writeEn,
	output lspPkg::word32 readData
);
	import lspPkg::*;

	// Full address space of the scratch RAM
	localparam int Depth = 1 << `LSP_ADDR_W;

	word32 ram [Depth];

	////////////////////////////////////////
	// Block RAM, one write and one read port
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (writeEn)
			ram[writeAddr] <= writeData;
		// Registered read, old data on collision
		readData <= ram[readAddr];
	end

endmodule

// ==== lspExpandFsm.sv ====
`timescale 1ns/100ps
`include "lspMacros.svh"

module lspExpandFsm
(
	input  logic clk,
	input  logic rstN,
	input  logic start,
	input  lspPkg::memAddr bufAddr,
	input  lspPkg::gapVal gap,
	input  lspPkg::word32 memIn,
	input  lspPkg::word16 aluResult,
	output lspPkg::word16 aluA,
	output lspPkg::word16 aluB,
	output lspPkg::aluOp aluOperation,
	output lspPkg::memAddr memReadAddr,
	output lspPkg::memAddr memWriteAddr,
	output lspPkg::word32 memOut,
	output logic memWriteEn,
	output logic done
);
	import lspPkg::*;

	// Index j runs 1 to M-1
	localparam int IdxW = $clog2(`LSP_M);
	localparam logic [IdxW-1:0] LastIdx = IdxW'(`LSP_M - 1);

	expandState state;
	expandState nextState;
	logic [IdxW-1:0] idx;

	// Latched at start
	memAddr baseReg;
	gapVal gapReg;

	// Working copies of buf[j-1] and buf[j]
	word16 bufA;
	word16 bufB;
	word16 diff;
	word16 shift;

	memAddr addrA;
	memAddr addrB;
	word16 gapWide;
	word16 writeVal;

	////////////////////////////////////////
	// State sequencing
	////////////////////////////////////////

	always_comb
	begin
		nextState = state;
		case (state)
			IDLE:
			begin
				if (start)
					nextState = READ_A;
			end
			READ_A: nextState = READ_B;
			READ_B: nextState = DIFF;
			DIFF: nextState = ADDGAP;
			ADDGAP: nextState = HALVE;
			HALVE:
			begin
				// Skip the update when already spaced
				if (aluResult > 0)
					nextState = UPDATE_A;
				else
					nextState = NEXT;
			end
			UPDATE_A: nextState = UPDATE_B;
			UPDATE_B: nextState = WRITE_A;
			WRITE_A: nextState = WRITE_B;
			WRITE_B: nextState = NEXT;
			NEXT: nextState = (idx == LastIdx) ? FINISH : READ_A;
			FINISH: nextState = IDLE;
			default: nextState = IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state <= IDLE;
			idx <= '0;
			done <= 1'b0;
		end
		else
		begin
			state <= nextState;
			// High for the FINISH cycle only
			done <= (state == NEXT) && (idx == LastIdx);
			if ((state == IDLE) && start)
				idx <= IdxW'(1);
			else if (state == NEXT)
				idx <= idx + 1'b1;
		end
	end

	////////////////////////////////////////
	// Working registers
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		case (state)
			IDLE:
			begin
				if (start)
				begin
					baseReg <= bufAddr;
					gapReg <= gap;
				end
			end
			// Read data lags the address by one clock
			READ_B: bufA <= word16'(memIn);
			DIFF:
			begin
				bufB <= word16'(memIn);
				diff <= aluResult;
			end
			ADDGAP: diff <= aluResult;
			HALVE: shift <= aluResult;
			UPDATE_A: bufA <= aluResult;
			UPDATE_B: bufB <= aluResult;
			default: ;
		endcase
	end

	////////////////////////////////////////
	// ALU steering
	////////////////////////////////////////

	assign gapWide = {{(16 - `LSP_GAP_W){1'b0}}, gapReg};

	always_comb
	begin
		aluA = bufA;
		aluB = bufB;
		aluOperation = ADD;
		case (state)
			// buf[j] straight from the RAM port
			DIFF:
			begin
				aluB = word16'(memIn);
				aluOperation = SUB;
			end
			ADDGAP:
			begin
				aluA = diff;
				aluB = gapWide;
			end
			HALVE:
			begin
				aluA = diff;
				aluOperation = SHR1;
			end
			UPDATE_A:
			begin
				aluB = shift;
				aluOperation = SUB;
			end
			UPDATE_B:
			begin
				aluA = bufB;
				aluB = shift;
			end
			default: ;
		endcase
	end

	////////////////////////////////////////
	// Memory port
	////////////////////////////////////////

	assign addrA = baseReg + memAddr'(idx) - memAddr'(1);
	assign addrB = baseReg + memAddr'(idx);

	assign memReadAddr = (state == READ_A) ? addrA : addrB;
	assign memWriteAddr = (state == WRITE_B) ? addrB : addrA;
	assign memWriteEn = (state == WRITE_A) || (state == WRITE_B);

	// Coefficient goes back sign-extended
	assign writeVal = (state == WRITE_B) ? bufB : bufA;
	assign memOut = {{(`LSP_DATA_W - 16){writeVal[15]}}, writeVal};

	doneOneCycle: assert property (@(posedge clk) disable iff (!rstN)
		done |=> !done);

	// Writes only on the update path and never straight out of IDLE
	noWriteInIdle: assert property (@(posedge clk) disable iff (!rstN)
		memWriteEn |-> (shift > 0) && ($past(state) != IDLE));

	// Offset from the latched base stays under M even across a wrap
	writeInsideBuf: assert property (@(posedge clk) disable iff (!rstN)
		memWriteEn |-> (memAddr'(memWriteAddr - baseReg) < `LSP_M));

endmodule

// ==== lspExpandPipe.sv ====
`timescale 1ns/100ps

module lspExpandPipe
(
	input  logic clk,
	input  logic rstN,
	input  logic start,
	input  lspPkg::memAddr bufAddr,
	input  lspPkg::gapVal gap,
	input  logic testSel,
	input  lspPkg::memAddr testReadAddr,
	input  lspPkg::memAddr testWriteAddr,
	input  lspPkg::word32 testWriteData,
	input  logic testWriteEn,
	output lspPkg::word32 memIn,
	output logic done
);
	import lspPkg::*;

	// FSM side of the RAM
	memAddr fsmReadAddr;
	memAddr fsmWriteAddr;
	word32 fsmWriteData;
	logic fsmWriteEn;

	// RAM side after the test muxes
	memAddr ramReadAddr;
	memAddr ramWriteAddr;
	word32 ramWriteData;
	logic ramWriteEn;

	// Shared ALU
	word16 aluA;
	word16 aluB;
	word16 aluResult;
	aluOp aluOperation;

	////////////////////////////////////////
	// Test port muxes
	////////////////////////////////////////

	// Read address
	always_comb
	begin
		case (testSel)
			1'b1: ramReadAddr = testReadAddr;
			default: ramReadAddr = fsmReadAddr;
		endcase
	end

	// Write address
	always_comb
	begin
		case (testSel)
			1'b1: ramWriteAddr = testWriteAddr;
			default: ramWriteAddr = fsmWriteAddr;
		endcase
	end

	// Write data
	always_comb
	begin
		case (testSel)
			1'b1: ramWriteData = testWriteData;
			default: ramWriteData = fsmWriteData;
		endcase
	end

	// Write enable
	always_comb
	begin
		case (testSel)
			1'b1: ramWriteEn = testWriteEn;
			default: ramWriteEn = fsmWriteEn;
		endcase
	end

	////////////////////////////////////////
	// Blocks
	////////////////////////////////////////

	scratchMemory mem0
	(
		.clk(clk),
		.writeAddr(ramWriteAddr),
		.readAddr(ramReadAddr),
		.writeData(ramWriteData),
		.writeEn(ramWriteEn),
		.readData(memIn)
	);

	satAlu16 alu0
	(
		.a(aluA),
		.b(aluB),
		.op(aluOperation),
		.result(aluResult)
	);

	// memIn also feeds the FSM
	lspExpandFsm fsm0
	(
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.bufAddr(bufAddr),
		.gap(gap),
		.memIn(memIn),
		.aluResult(aluResult),
		.aluA(aluA),
		.aluB(aluB),
		.aluOperation(aluOperation),
		.memReadAddr(fsmReadAddr),
		.memWriteAddr(fsmWriteAddr),
		.memOut(fsmWriteData),
		.memWriteEn(fsmWriteEn),
		.done(done)
	);

endmodule

// ==== tbClockGen.sv ====
`timescale 1ns/100ps

module tbClockGen
(
	output logic clk,
	output logic rstN
);
	// Cycles with reset held low
	localparam int ResetCycles = 16;

	// 100 ns period
	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial
	begin
		rstN = 1'b0;
		repeat (ResetCycles) @(posedge clk);
		// Released on a falling edge with the rest of the stimulus
		@(negedge clk);
		rstN = 1'b1;
	end

endmodule

// ==== lspExpandChecker.sv ====
`timescale 1ns/100ps
`include "lspMacros.svh"

module lspExpandChecker
#(
	parameter int NumPasses = 10
)
(
	input  logic clk,
	input  logic rstN,
	input  logic start,
	input  lspPkg::memAddr bufAddr,
	input  lspPkg::gapVal gap,
	input  logic done,
	input  logic testSel,
	input  lspPkg::memAddr testReadAddr,
	input  lspPkg::memAddr testWriteAddr,
	input  lspPkg::word32 testWriteData,
	input  logic testWriteEn,
	input  lspPkg::word32 memIn,
	input  logic readCheck,
	input  int testNum,
	input  logic testEnd,
	input  logic allDone,
	output int passCount,
	output int failCount,
	output logic timedOut
);
	import lspPkg::*;

	// Cycles per index, skipped or written back
	localparam int SkipCycles = 6;
	localparam int UpdateCycles = 10;
	localparam int MaxLatency = 9 * 10 + 2;
	localparam int MemWords = 1 << `LSP_ADDR_W;

	// Load with guards, pass, readback with guards, test end
	localparam int PassCycles = (`LSP_M + 3) + (MaxLatency + 3) + (`LSP_M + 3) + 2;
	localparam int TimeoutCycles = 16 + NumPasses * PassCycles + 50;

	// Mirror of the scratch RAM
	word32 shadow [MemWords];

	logic busy;
	logic pend;
	memAddr pendAddr;
	memAddr pendBase;
	word32 expWord;
	int offset;
	int waitCycles;
	int expLatency;
	int nUpd;
	int testErrors;
	int testChecks;
	int cycleCount = 0;

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	// Clamp to the 16-bit range
	function automatic int sat16(input int v);
		if (v > 32767)
			return 32767;
		else if (v < -32768)
			return -32768;
		return v;
	endfunction

	// Expand pass on the mirror, returns how many indices were updated
	function automatic int refExpand(input memAddr base, input gapVal g);
		int j;
		int a;
		int b;
		int d;
		int t;
		int updates;
		memAddr addrA;
		memAddr addrB;
		updates = 0;
		for (j = 1; j < `LSP_M; j++)
		begin
			// Buffer may wrap past the top of the RAM
			addrA = memAddr'(int'(base) + j - 1);
			addrB = memAddr'(int'(base) + j);
			a = int'(word16'(shadow[addrA][15:0]));
			b = int'(word16'(shadow[addrB][15:0]));
			d = sat16(a - b);
			t = sat16(d + int'(g)) >>> 1;
			if (t > 0)
			begin
				a = sat16(a - t);
				b = sat16(b + t);
				// int keeps the sign into all 32 bits
				shadow[addrA] = word32'(a);
				shadow[addrB] = word32'(b);
				updates++;
			end
		end
		return updates;
	endfunction

	function automatic string testName(input int n);
		case (n)
			1: return "ascending gap 10";
			2: return "unsorted gap 5";
			3: return "already spaced";
			4: return "saturation";
			5: return "two buffers";
			default: return "unknown";
		endcase
	endfunction

	////////////////////////////////////////
	// Compare process
	////////////////////////////////////////

	always @(posedge clk)
	begin
		if (!rstN)
		begin
			busy = 1'b0;
			pend = 1'b0;
			passCount = 0;
			failCount = 0;
			testErrors = 0;
			testChecks = 0;
		end
		else
		begin
			// Read data lags the address by one clock
			if (pend)
			begin
				testChecks++;
				expWord = shadow[pendAddr];
				if (memIn !== expWord)
				begin
					// Index relative to the buffer, guards at -1 and M
					offset = int'(memAddr'(pendAddr - pendBase));
					if (offset >= MemWords / 2)
						offset -= MemWords;
					$display("** Error %s: index %0d expected %h actual %h",
						testName(testNum), offset, expWord, memIn);
					testErrors++;
				end
			end
			pend = readCheck && testSel;
			pendAddr = testReadAddr;
			pendBase = bufAddr;

			// Track test port writes
			if (testSel && testWriteEn)
				shadow[testWriteAddr] = testWriteData;

			if (busy)
			begin
				waitCycles++;
				if (done)
				begin
					busy = 1'b0;
					if (waitCycles != expLatency)
					begin
						$display("** Error %s: latency expected %0d actual %0d",
							testName(testNum), expLatency, waitCycles);
						testErrors++;
					end
				end
				else if (waitCycles > MaxLatency)
				begin
					$display("Test %s: done did not arrive within %0d cycles of start",
						testName(testNum), MaxLatency);
					testErrors++;
					busy = 1'b0;
				end
			end
			else if (start && !testSel)
			begin
				busy = 1'b1;
				waitCycles = 0;
				nUpd = refExpand(bufAddr, gap);
				// done is seen one clock after FINISH is entered
				expLatency = 1 + (`LSP_M - 1 - nUpd) * SkipCycles + nUpd * UpdateCycles;
			end

			if (testEnd)
			begin
				if (testChecks == 0)
				begin
					$display("Test %s: no words were read back", testName(testNum));
					testErrors++;
				end
				if (testErrors == 0)
					passCount++;
				else
					failCount++;
				$display("Test %0d %s: %s, %0d words checked, %0d errors", testNum,
					testName(testNum), (testErrors == 0) ? "pass" : "fail",
					testChecks, testErrors);
				testErrors = 0;
				testChecks = 0;
			end

			if (allDone)
				$display("Summary: %0d tests passed, %0d tests failed", passCount, failCount);
		end
	end

	////////////////////////////////////////
	// Run limit
	////////////////////////////////////////

	assign timedOut = (cycleCount >= TimeoutCycles);

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == TimeoutCycles - 1)
			$display("Timeout: run still going after %0d cycles", TimeoutCycles);
	end

endmodule

// ==== lspExpandTb.sv ====
`timescale 1ns/100ps
`include "lspMacros.svh"

module lspExpandTb;
	import lspPkg::*;

	// Highest base that leaves room for the upper guard
	localparam int MaxBase = (1 << `LSP_ADDR_W) - `LSP_M - 1;

	logic clk;
	logic rstN;
	logic start;
	memAddr bufAddr;
	gapVal gap;
	logic testSel;
	memAddr testReadAddr;
	memAddr testWriteAddr;
	word32 testWriteData;
	logic testWriteEn;
	word32 memIn;
	logic done;

	// Checker side channel
	logic readCheck;
	logic testEnd;
	logic allDone;
	int testNum;
	int passCount;
	int failCount;
	logic timedOut;

	// Next buffer to load
	word16 coef [`LSP_M];

	tbClockGen clkGen0
	(
		.clk(clk),
		.rstN(rstN)
	);

	lspExpandPipe dut0
	(
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.bufAddr(bufAddr),
		.gap(gap),
		.testSel(testSel),
		.testReadAddr(testReadAddr),
		.testWriteAddr(testWriteAddr),
		.testWriteData(testWriteData),
		.testWriteEn(testWriteEn),
		.memIn(memIn),
		.done(done)
	);

	lspExpandChecker #(.NumPasses(10)) chk0
	(
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.bufAddr(bufAddr),
		.gap(gap),
		.done(done),
		.testSel(testSel),
		.testReadAddr(testReadAddr),
		.testWriteAddr(testWriteAddr),
		.testWriteData(testWriteData),
		.testWriteEn(testWriteEn),
		.memIn(memIn),
		.readCheck(readCheck),
		.testNum(testNum),
		.testEnd(testEnd),
		.allDone(allDone),
		.passCount(passCount),
		.failCount(failCount),
		.timedOut(timedOut)
	);

	////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////

	// Guard word built from the whole address
	function automatic word32 guardWord(input memAddr addr);
		return {5'h15, addr, 5'h0A, addr};
	endfunction

	// Start value plus random steps
	task automatic fillRandom(input int lo, input int span, input int stepLo, input int stepSpan);
		int i;
		int v;
		v = lo + int'($urandom_range(0, span));
		for (i = 0; i < `LSP_M; i++)
		begin
			coef[i] = word16'(v);
			v = v + stepLo + int'($urandom_range(0, stepSpan));
		end
	endtask

	task automatic writeWord(input memAddr addr, input word32 data);
		@(negedge clk);
		testSel = 1'b1;
		testWriteAddr = addr;
		testWriteData = data;
		testWriteEn = 1'b1;
	endtask

	// Buffer plus one guard word on each side
	task automatic loadBuffer(input memAddr base);
		int i;
		writeWord(memAddr'(int'(base) - 1), guardWord(memAddr'(int'(base) - 1)));
		for (i = 0; i < `LSP_M; i++)
			writeWord(memAddr'(int'(base) + i), {{16{coef[i][15]}}, coef[i]});
		writeWord(memAddr'(int'(base) + `LSP_M), guardWord(memAddr'(int'(base) + `LSP_M)));
		@(negedge clk);
		testWriteEn = 1'b0;
	endtask

	task automatic runPass(input memAddr base, input gapVal g);
		int waited;
		@(negedge clk);
		testSel = 1'b0;
		bufAddr = base;
		gap = g;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		// Bounded wait, a late done is reported by the checker
		waited = 0;
		while (!done && waited < 100)
		begin
			@(negedge clk);
			waited++;
		end
		// FINISH over, FSM idle again
		@(negedge clk);
	endtask

	task automatic readBack(input memAddr base);
		int k;
		for (k = -1; k <= `LSP_M; k++)
		begin
			@(negedge clk);
			testSel = 1'b1;
			readCheck = 1'b1;
			bufAddr = base;
			testReadAddr = memAddr'(int'(base) + k);
		end
		@(negedge clk);
		readCheck = 1'b0;
	endtask

	task automatic endTest();
		@(negedge clk);
		testEnd = 1'b1;
		@(negedge clk);
		testEnd = 1'b0;
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial
	begin
		int p;
		memAddr base;
		start = 1'b0;
		bufAddr = '0;
		gap = '0;
		testSel = 1'b1;
		testReadAddr = '0;
		testWriteAddr = '0;
		testWriteData = '0;
		testWriteEn = 1'b0;
		readCheck = 1'b0;
		testEnd = 1'b0;
		allDone = 1'b0;
		testNum = 0;
		void'($urandom(57));
		@(posedge rstN);

		// Random ascending, steps near the gap
		testNum = 1;
		for (p = 0; p < 3; p++)
		begin
			base = memAddr'($urandom_range(1, MaxBase));
			fillRandom(-1000, 2000, 0, 30);
			loadBuffer(base);
			runPass(base, gapVal'(10));
			readBack(base);
		end
		endTest();

		// Close and crossing neighbours
		testNum = 2;
		for (p = 0; p < 3; p++)
		begin
			base = memAddr'($urandom_range(1, MaxBase));
			fillRandom(-500, 1000, -20, 40);
			loadBuffer(base);
			runPass(base, gapVal'(5));
			readBack(base);
		end
		endTest();

		// Spacing of 600, well over the gap
		testNum = 3;
		fillRandom(-3000, 0, 600, 0);
		loadBuffer(memAddr'(400));
		runPass(memAddr'(400), gapVal'(15));
		readBack(memAddr'(400));
		endTest();

		// Rails on both ends, crossing pairs
		testNum = 4;
		coef[0] = -16'sd32768;
		coef[1] = -16'sd32768;
		coef[2] = -16'sd32760;
		coef[3] = 16'sd32767;
		coef[4] = -16'sd32768;
		coef[5] = 16'sd0;
		coef[6] = 16'sd32760;
		coef[7] = 16'sd32767;
		coef[8] = 16'sd32767;
		coef[9] = 16'sd32767;
		loadBuffer(memAddr'(1000));
		runPass(memAddr'(1000), gapVal'(15));
		readBack(memAddr'(1000));
		endTest();

		// Bottom buffer guard wraps to the top word
		testNum = 5;
		fillRandom(-500, 1000, -20, 40);
		loadBuffer(memAddr'(0));
		fillRandom(-500, 1000, -20, 40);
		loadBuffer(memAddr'(MaxBase));
		runPass(memAddr'(0), gapVal'(7));
		runPass(memAddr'(MaxBase), gapVal'(7));
		readBack(memAddr'(0));
		readBack(memAddr'(MaxBase));
		endTest();

		@(negedge clk);
		allDone = 1'b1;
		@(negedge clk);
		if (failCount == 0 && passCount == 5)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// Run limit reached
	initial
	begin
		@(posedge timedOut);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+.
lspPkg.sv
satAlu16.sv
scratchMemory.sv
lspExpandFsm.sv
lspExpandPipe.sv
tbClockGen.sv
lspExpandChecker.sv
lspExpandTb.sv
